// File: list.f
+incdir+src
src/prbs_cfg_pkg.sv
src/prbs_stream_pkg.sv
src/lfsr_core.sv
src/prbs_generator.sv
src/prbs_fifo.sv
src/prbs_checker.sv
src/prbs_link_top.sv
tb/tb_clk_gen.sv
tb/prbs_link_sva.sv
tb/prbs_link_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= prbs_link_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   ?= TEST FAILED
PASS_MSG   ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/prbs_link_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "prbs_macros.svh"

module prbs_link_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 12;                // Start held low after reset
    localparam int N_BEATS        = 800;               // A little over three periods
    localparam int PERIOD         = 255;               // Maximal length for taps 8,6,5,4
    localparam int INJECT_FROM    = 100;               // First stretch runs without errors
    localparam int INJECT_GAP     = 20;                // Minimum beats between injections
    localparam int FIFO_DEPTH     = `PRBS_FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = 3 * N_BEATS + 600; // Up to three cycles a beat, plus drain

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    prbs_cfg_pkg::prbs_word_t     seed;
    prbs_cfg_pkg::tap_set_t       taps;
    logic                         inject;
    logic                         sink_stall;
    prbs_stream_pkg::chk_status_t status;
    logic                         src_valid;
    logic                         src_ready;

    int          src_xfers;       // Beats that left the generator
    int          injected;        // Of those, beats that carried an error
    int          accepted;        // Words compared after the seed word
    int          exp_err;         // Injected beats among the compared words
    int          level;           // Beats waiting in the FIFO
    int          chk_phase;       // 0 no seed yet, 1 seeding cycle, 2 tracking
    logic        src_on;          // Generator should offer a beat
    logic        armed;           // Inject pulse still waiting for a transfer
    logic        start_q;         // Start level at the previous rising edge
    logic        h_valid;         // Source handshake seen before the last rising edge
    logic        h_ready;
    logic        inj_q [$];       // Error mark of every beat not yet taken by the checker
    int          stall_left;
    int          last_inject_at;
    int unsigned lcg_state;
    int          cycle_count = 0;

    tb_clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.o_clk(clk));

    prbs_link_top i_prbs_link_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_seed       (seed),
        .i_taps       (taps),
        .i_inject     (inject),
        .i_sink_stall (sink_stall),
        .o_status     (status),
        .o_src_valid  (src_valid),
        .o_src_ready  (src_ready)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("ERROR at %0d ns: %s", $time, what));
    endtask

    // Replays the rising edge that just passed, inputs still hold the values it sampled
    task automatic advance_model();
        logic xfer;
        logic mark;
        xfer = h_valid & h_ready;
        if (chk_phase == 2) begin
            if (level > 0 && !sink_stall) begin                // Head beat is compared
                mark = inj_q.pop_front();
                level--;
                accepted++;
                if (mark) begin
                    exp_err++;
                end
            end
        end else if (chk_phase == 1) begin
            chk_phase = 2;                                     // Checker takes no beat while seeding
        end else if (level > 0 && !sink_stall) begin
            mark = inj_q.pop_front();                          // Seed word, never corrupted
            level--;
            chk_phase = 1;
        end
        if (xfer) begin
            src_xfers++;
            level++;                                           // Visible to the checker next edge
            inj_q.push_back(armed);
            if (armed) begin
                injected++;
            end
            armed = 1'b0;
        end
        if (inject) begin
            armed = 1'b1;                                      // Hits the next transfer
        end
        if (start && !start_q && !src_on) begin
            src_on = 1'b1;
        end else if (xfer) begin
            src_on = start;                                    // Stops only after a beat leaves
        end
        start_q = start;
    endtask

    task automatic check_outputs();
        assert (src_valid == src_on)
            else report_mismatch($sformatf("o_src_valid %0b, expected %0b", src_valid, src_on));
        assert (src_ready == (level < FIFO_DEPTH))
            else report_mismatch($sformatf("o_src_ready %0b with %0d beats held",
                                           src_ready, level));
        assert (status.locked == (chk_phase != 0))
            else report_mismatch($sformatf("locked %0b, expected %0b",
                                           status.locked, chk_phase != 0));
        assert (status.word_count == prbs_cfg_pkg::cnt_t'(accepted))
            else report_mismatch($sformatf("word_count %0d, expected %0d",
                                           status.word_count, accepted));
        assert (status.err_count == prbs_cfg_pkg::cnt_t'(exp_err))
            else report_mismatch($sformatf("err_count %0d, expected %0d",
                                           status.err_count, exp_err));
        assert (status.wrap_count == prbs_cfg_pkg::cnt_t'(accepted / PERIOD))
            else report_mismatch($sformatf("wrap_count %0d after %0d words",
                                           status.wrap_count, accepted));
        // Seed word, compared words and FIFO contents account for every source beat
        assert (int'(status.word_count) + int'(status.locked) + level == src_xfers)
            else report_mismatch($sformatf("%0d words plus %0d held, %0d beats sent",
                                           status.word_count, level, src_xfers));
        assert (i_prbs_link_top.u_prbs_link_sva.n_fail == 0)
            else stop_with_failure("A bound assertion on the DUT ports failed");
    endtask

    task automatic tick();
        @(negedge clk);
        advance_model();
        check_outputs();
        h_valid = src_valid;                                   // Handshake for the coming edge
        h_ready = src_ready;
    endtask

    task automatic drive_cycle();
        int unsigned r;
        r = lcg_next();
        if (stall_left > 0) begin
            stall_left--;
        end else if (r[18:16] == 3'd0) begin
            stall_left = 1 + int'(r[21:19]);                   // Burst of one to eight cycles
        end
        sink_stall = (stall_left > 0);
        inject     = 1'b0;
        if (src_xfers >= INJECT_FROM && (src_xfers - last_inject_at) >= INJECT_GAP &&
            r[27:24] == 4'd0) begin
            inject         = 1'b1;
            last_inject_at = src_xfers;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, no result after %0d clock cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        seed       = prbs_cfg_pkg::prbs_word_t'(1);
        taps.tap0  = prbs_cfg_pkg::tap_idx_t'(8);
        taps.tap1  = prbs_cfg_pkg::tap_idx_t'(6);
        taps.tap2  = prbs_cfg_pkg::tap_idx_t'(5);
        taps.tap3  = prbs_cfg_pkg::tap_idx_t'(4);
        inject     = 1'b0;
        sink_stall = 1'b0;
        src_xfers  = 0;
        injected   = 0;
        accepted   = 0;
        exp_err    = 0;
        level      = 0;
        chk_phase  = 0;
        src_on     = 1'b0;
        armed      = 1'b0;
        start_q    = 1'b0;
        h_valid    = 1'b0;
        h_ready    = 1'b0;
        stall_left = 0;
        last_inject_at = 0;
        lcg_state  = 27;
        repeat (RESET_CYCLES) tick();
        rst_n = 1'b1;
        repeat (IDLE_CYCLES) tick();                           // Outputs must stay at zero
        start = 1'b1;
        while (src_xfers < N_BEATS) begin
            tick();
            drive_cycle();
        end
        start      = 1'b0;
        inject     = 1'b0;
        sink_stall = 1'b0;                                     // Let the FIFO drain
        while (src_on || (accepted + 1 != src_xfers)) begin
            tick();
        end
        repeat (8) tick();
        assert (int'(status.word_count) + 1 == src_xfers)
            else report_mismatch($sformatf("final word_count %0d for %0d beats sent",
                                           status.word_count, src_xfers));
        assert (status.err_count == prbs_cfg_pkg::cnt_t'(injected))
            else report_mismatch($sformatf("final err_count %0d for %0d injections",
                                           status.err_count, injected));
        if (injected == 0 || accepted < 3 * PERIOD) begin
            stop_with_failure("The run ended without an injection or three full periods");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule : prbs_link_tb

`default_nettype wire

// File: tb/prbs_link_sva.sv
`default_nettype none
`timescale 1ns/100ps

module prbs_link_sva (
    input logic                         i_clk,
    input logic                         i_rst_n,
    input logic                         i_start,
    input logic                         i_sink_stall,
    input prbs_stream_pkg::chk_status_t i_status,
    input logic                         i_src_valid,
    input logic                         i_src_ready
);

    int unsigned n_fail = 0;  // Failed assertions so far, the testbench watches it

    // Lock is only lost through reset
    a_lock_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_status.locked |=> i_status.locked)
        else begin
            $error("locked fell while running");
            n_fail = n_fail + 1;
        end

    a_idle_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_status.locked |-> (i_status.word_count == '0 && i_status.err_count == '0 &&
                              i_status.wrap_count == '0))
        else begin
            $error("a counter moved before lock");
            n_fail = n_fail + 1;
        end

    // A stalled sink takes no beat, so the word count cannot move on the next edge
    a_stall_freezes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sink_stall |=> $stable(i_status.word_count))
        else begin
            $error("word_count changed under stall");
            n_fail = n_fail + 1;
        end

    a_word_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_status.word_count != $past(i_status.word_count)) |->
        (i_status.word_count == $past(i_status.word_count) + prbs_cfg_pkg::cnt_t'(1)))
        else begin
            $error("word_count jumped by more than one");
            n_fail = n_fail + 1;
        end

    // Errors and wraps are only counted on a compared word
    a_counts_with_word: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((i_status.err_count != $past(i_status.err_count)) ||
         (i_status.wrap_count != $past(i_status.wrap_count))) |->
        (i_status.word_count != $past(i_status.word_count)))
        else begin
            $error("err_count or wrap_count moved without a word");
            n_fail = n_fail + 1;
        end

    a_src_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_src_valid && !i_src_ready) |=> i_src_valid)
        else begin
            $error("source valid dropped before transfer");
            n_fail = n_fail + 1;
        end

    a_no_start_no_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_src_valid && !i_start) |=> !i_src_valid)
        else begin
            $error("source valid rose without start");
            n_fail = n_fail + 1;
        end

endmodule : prbs_link_sva

bind prbs_link_top prbs_link_sva u_prbs_link_sva (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_sink_stall (i_sink_stall),
    .i_status     (o_status),
    .i_src_valid  (o_src_valid),
    .i_src_ready  (o_src_ready)
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0   // Full clock period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;                // Low at time zero, first rising edge after half a period
    end

    always begin
        #(PERIOD_NS / 2.0);
        o_clk = ~o_clk;
    end

endmodule : tb_clk_gen

`default_nettype wire

// File: src/prbs_link_top.sv
`default_nettype none
`timescale 1ns/100ps

module prbs_link_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  prbs_cfg_pkg::prbs_word_t     i_seed,
    input  prbs_cfg_pkg::tap_set_t       i_taps,       // Shared by both shift registers
    input  logic                         i_inject,
    input  logic                         i_sink_stall,
    output prbs_stream_pkg::chk_status_t o_status,
    output logic                         o_src_valid,  // Generator hop handshake
    output logic                         o_src_ready
);

    prbs_stream_pkg::prbs_beat_t src_beat;   // Generator to FIFO
    prbs_stream_pkg::prbs_beat_t snk_beat;   // FIFO to checker
    logic                        snk_valid;
    logic                        snk_ready;

    prbs_generator u_prbs_generator (
        .i_clk   (i_clk),      .i_rst_n (i_rst_n),
        .i_start (i_start),    .i_seed  (i_seed),
        .i_taps  (i_taps),     .i_inject(i_inject),
        .i_ready (o_src_ready),
        .o_valid (o_src_valid), .o_beat (src_beat)
    );

    prbs_fifo u_prbs_fifo (
        .i_clk   (i_clk),       .i_rst_n (i_rst_n),
        .i_valid (o_src_valid), .i_beat  (src_beat), .o_ready (o_src_ready),
        .o_valid (snk_valid),   .o_beat  (snk_beat), .i_ready (snk_ready)
    );

    prbs_checker u_prbs_checker (
        .i_clk   (i_clk),     .i_rst_n (i_rst_n),
        .i_taps  (i_taps),    .i_valid (snk_valid),
        .i_beat  (snk_beat),  .i_stall (i_sink_stall),
        .o_ready (snk_ready), .o_status(o_status)
    );

endmodule : prbs_link_top

`default_nettype wire

// File: src/prbs_checker.sv
`default_nettype none
`timescale 1ns/100ps

module prbs_checker (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  prbs_cfg_pkg::tap_set_t       i_taps,
    input  logic                         i_valid,
    input  prbs_stream_pkg::prbs_beat_t  i_beat,
    input  logic                         i_stall,   // Sink back-pressure
    output logic                         o_ready,
    output prbs_stream_pkg::chk_status_t o_status
);

    prbs_stream_pkg::chk_state_t  r_state;
    prbs_stream_pkg::chk_status_t r_status;
    prbs_cfg_pkg::prbs_word_t     r_seed;        // First word received
    prbs_cfg_pkg::prbs_word_t     w_core_seed;
    prbs_cfg_pkg::prbs_word_t     w_predict;     // Word expected on the next beat
    logic                         w_at_seed;
    logic                         w_accept;
    logic                         w_idle;
    logic                         w_track;
    logic                         w_core_en;

    assign w_idle   = (r_state == prbs_stream_pkg::IDLE);
    assign w_track  = (r_state == prbs_stream_pkg::TRACK);
    // No beat is taken while the core moves past the seed
    assign o_ready  = ~i_stall & (r_state != prbs_stream_pkg::ACQUIRE);
    assign w_accept = i_valid & o_ready;

    // In IDLE the core loads straight from the incoming beat
    assign w_core_seed = w_idle ? i_beat.data : r_seed;
    assign w_core_en   = w_accept | (r_state == prbs_stream_pkg::ACQUIRE);  // ACQUIRE always steps

    lfsr_core u_lfsr_core (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (w_core_en),
        .i_seed_load (w_idle),         // Step in ACQUIRE and TRACK
        .i_seed      (w_core_seed),
        .i_taps      (i_taps),
        .o_data      (w_predict),
        .o_at_seed   (w_at_seed)
    );

    always_ff @(posedge i_clk) begin
        if (w_idle && w_accept) begin
            r_seed <= i_beat.data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state  <= prbs_stream_pkg::IDLE;
            r_status <= '0;
        end else begin
            case (r_state)
                prbs_stream_pkg::IDLE: begin
                    if (w_accept) begin
                        r_state         <= prbs_stream_pkg::ACQUIRE;
                        r_status.locked <= 1'b1;              // Held until reset
                    end
                end
                prbs_stream_pkg::ACQUIRE: begin
                    r_state <= prbs_stream_pkg::TRACK;        // Core now predicts word two
                end
                default: begin
                    r_state <= prbs_stream_pkg::TRACK;
                end
            endcase
            if (w_track && w_accept) begin
                r_status.word_count <= r_status.word_count + 1'b1;
                if (i_beat.data != w_predict) begin
                    r_status.err_count <= r_status.err_count + 1'b1;
                end
                if (w_at_seed) begin
                    r_status.wrap_count <= r_status.wrap_count + 1'b1;  // Seed repeats here
                end
            end
        end
    end

    assign o_status = r_status;

endmodule : prbs_checker

`default_nettype wire

// File: src/prbs_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "prbs_macros.svh"

module prbs_fifo (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,   // Write side
    input  prbs_stream_pkg::prbs_beat_t i_beat,
    output logic                        o_ready,
    output logic                        o_valid,   // Read side
    output prbs_stream_pkg::prbs_beat_t o_beat,
    input  logic                        i_ready
);

    localparam int DEPTH = `PRBS_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    prbs_stream_pkg::prbs_beat_t r_mem [DEPTH];   // Beat storage
    logic [AW:0]                 r_wr_ptr;        // Top bit counts laps of the buffer
    logic [AW:0]                 r_rd_ptr;
    logic                        w_empty;
    logic                        w_full;
    logic                        w_wr;            // Beat accepted from the generator
    logic                        w_rd;            // Beat taken by the checker

    assign w_empty = (r_wr_ptr == r_rd_ptr);
    // Same slot but one lap apart means every entry holds a beat
    assign w_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
                     (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);

    assign o_ready = ~w_full;
    assign o_valid = ~w_empty;
    assign w_wr    = i_valid & o_ready;
    assign w_rd    = o_valid & i_ready;

    always_ff @(posedge i_clk) begin
        if (w_wr) begin
            r_mem[r_wr_ptr[AW-1:0]] <= i_beat;
        end
    end

    // Both pointers may move on the same edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (w_wr) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_rd) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
        end
    end

    assign o_beat = r_mem[r_rd_ptr[AW-1:0]];      // Head entry, held until it is read

endmodule : prbs_fifo

`default_nettype wire

// File: src/prbs_generator.sv
`default_nettype none
`timescale 1ns/100ps

module prbs_generator (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,    // Level, a rising edge restarts the sequence
    input  prbs_cfg_pkg::prbs_word_t    i_seed,
    input  prbs_cfg_pkg::tap_set_t      i_taps,
    input  logic                        i_inject,   // Pulse, corrupts one later beat
    input  logic                        i_ready,
    output logic                        o_valid,
    output prbs_stream_pkg::prbs_beat_t o_beat
);

    prbs_cfg_pkg::prbs_word_t w_core_data;
    logic                     w_at_seed;
    logic                     w_load;       // Start edge while no beat is pending
    logic                     w_xfer;       // Beat leaves on this edge
    logic                     r_start_d;    // Last cycle's start level
    logic                     r_valid;
    logic                     r_inject;     // Armed error waiting for a transfer
    logic                     r_first;      // Seed word on offer, it closes no period

    assign w_load = i_start & ~r_start_d & ~r_valid;
    assign w_xfer = r_valid & i_ready;

    lfsr_core u_lfsr_core (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (w_load | w_xfer),     // Only a transfer moves the sequence on
        .i_seed_load (w_load),
        .i_seed      (i_seed),
        .i_taps      (i_taps),
        .o_data      (w_core_data),
        .o_at_seed   (w_at_seed)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_start_d <= 1'b0;
            r_valid   <= 1'b0;
            r_inject  <= 1'b0;
            r_first   <= 1'b0;
        end else begin
            r_start_d <= i_start;
            if (w_load) begin
                r_valid <= 1'b1;            // Seed word goes out next cycle
            end else if (w_xfer) begin
                r_valid <= i_start;         // Stop only between beats
            end
            if (i_inject) begin
                r_inject <= 1'b1;           // A new pulse wins over the clear
            end else if (w_xfer) begin
                r_inject <= 1'b0;
            end
            if (w_load) begin
                r_first <= 1'b1;
            end else if (w_xfer) begin
                r_first <= 1'b0;
            end
        end
    end

    always_comb begin
        o_valid     = r_valid;
        o_beat.data = w_core_data ^ {{($bits(w_core_data)-1){1'b0}}, r_inject};
        o_beat.wrap = w_at_seed & ~r_first; // Seed seen again after a full period
    end

endmodule : prbs_generator

`default_nettype wire

// File: src/lfsr_core.sv
`default_nettype none
`timescale 1ns/100ps

module lfsr_core (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_enable,     // Load or step on this cycle
    input  logic                     i_seed_load,  // Takes the seed instead of stepping
    input  prbs_cfg_pkg::prbs_word_t i_seed,
    input  prbs_cfg_pkg::tap_set_t   i_taps,
    output prbs_cfg_pkg::prbs_word_t o_data,
    output logic                     o_at_seed     // Register has come back to the seed
);

    localparam int W = $bits(prbs_cfg_pkg::prbs_word_t);

    logic [W:1] r_lfsr;   // Bit positions numbered like the tap indices
    logic [W:1] w_mask;   // One bit set per tap in use
    logic       w_fb;     // Bit shifted in at the bottom

    // Index zero never matches a position, so an unused tap adds nothing to the mask
    always_comb begin
        w_mask = '0;
        for (int i = 1; i <= W; i++) begin
            if ((i_taps.tap0 == prbs_cfg_pkg::tap_idx_t'(i)) ||
                (i_taps.tap1 == prbs_cfg_pkg::tap_idx_t'(i)) ||
                (i_taps.tap2 == prbs_cfg_pkg::tap_idx_t'(i)) ||
                (i_taps.tap3 == prbs_cfg_pkg::tap_idx_t'(i))) begin
                w_mask[i] = 1'b1;
            end
        end
    end

    assign w_fb = ~^(r_lfsr & w_mask);  // XNOR form, the all-ones word is the lock-up state

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_lfsr <= '0;
        end else if (i_enable) begin
            if (i_seed_load) begin
                r_lfsr <= i_seed;                     // Restart the sequence
            end else begin
                r_lfsr <= {r_lfsr[W-1:1], w_fb};      // Shift towards the top bit
            end
        end
    end

    assign o_data    = r_lfsr;
    assign o_at_seed = (r_lfsr == i_seed);            // Seed must stay put while running

endmodule : lfsr_core

`default_nettype wire

// File: src/prbs_stream_pkg.sv
`default_nettype none

package prbs_stream_pkg;

    typedef struct packed {
        prbs_cfg_pkg::prbs_word_t data;     // Sequence word, bit 0 may carry an injected error
        logic                     wrap;     // Generator is back at the seed on this word
    } prbs_beat_t;

    typedef struct packed {
        logic                locked;        // Checker has taken its seed from the stream
        prbs_cfg_pkg::cnt_t  err_count;     // Words that differed from the prediction
        prbs_cfg_pkg::cnt_t  word_count;    // Words compared after the seed word
        prbs_cfg_pkg::cnt_t  wrap_count;    // Times the prediction came back to the seed
    } chk_status_t;

    typedef enum logic [1:0] {
        IDLE,                               // Waiting for the first beat
        ACQUIRE,                            // Seed loaded, core steps to the second word
        TRACK                               // Comparing every accepted beat
    } chk_state_t;

endpackage : prbs_stream_pkg

`default_nettype wire

// File: src/prbs_cfg_pkg.sv
`default_nettype none

`include "prbs_macros.svh"

package prbs_cfg_pkg;

    typedef logic [`PRBS_WIDTH-1:0] prbs_word_t;  // One word of the sequence

    typedef logic [`PRBS_TAP_W-1:0] tap_idx_t;    // Tap position, zero leaves the tap unused

    typedef struct packed {
        tap_idx_t tap0;                            // Usually the register width itself
        tap_idx_t tap1;
        tap_idx_t tap2;
        tap_idx_t tap3;
    } tap_set_t;

    typedef logic [`PRBS_CNT_W-1:0] cnt_t;        // Plain wrapping event counter

endpackage : prbs_cfg_pkg

`default_nettype wire

// File: src/prbs_macros.svh
`ifndef PRBS_MACROS_SVH
`define PRBS_MACROS_SVH

`define PRBS_WIDTH 8       // Shift register width, taps 8,6,5,4 give period 255

`define PRBS_TAP_W 4       // Tap index width, addresses positions 1 to 15

`define PRBS_FIFO_DEPTH 4  // Beat buffer entries, kept a power of two

`define PRBS_CNT_W 16      // Width of every checker event counter

`endif
